// File: rtl/ctl_consts.svh
`ifndef CTL_CONSTS_SVH
`define CTL_CONSTS_SVH

// ==================================================
// widths
// ==================================================

// instruction address
`define CTL_PC_WIDTH 32

// mtvec and mepc
`define CTL_XLEN 32

// exception code field
`define CTL_CAUSE_BITS 4

// encodings of the controller enums
`define CTL_STATE_BITS 4
`define CTL_SRC_BITS 3

// ==================================================
// machine trap cause codes
// ==================================================
`define CTL_CAUSE_INSTR_MISALIGN 4'd0
`define CTL_CAUSE_BREAKPOINT 4'd3
`define CTL_CAUSE_LOAD_MISALIGN 4'd4
`define CTL_CAUSE_STORE_MISALIGN 4'd6
`define CTL_CAUSE_ECALL_M 4'd11

// machine timer interrupt, reported with is_interrupt high
`define CTL_CAUSE_TIMER 4'd7

`endif

// File: rtl/ctl_pkg.sv
`include "ctl_consts.svh"

package ctl_pkg;

    // controller states
    typedef enum logic [`CTL_STATE_BITS-1:0] {
        st_init,
        st_init_wait,
        st_fetch,
        st_decode,
        st_fetch_exe,
        st_decode_data,
        st_store,
        st_store_wait,
        st_load,
        st_load_wait,
        st_exception,
        st_exception_reinit
    } ctl_state_e;

    // mcause exception code
    typedef enum logic [`CTL_CAUSE_BITS-1:0] {
        cause_instr_misalign = `CTL_CAUSE_INSTR_MISALIGN,
        cause_breakpoint     = `CTL_CAUSE_BREAKPOINT,
        cause_load_misalign  = `CTL_CAUSE_LOAD_MISALIGN,
        cause_store_misalign = `CTL_CAUSE_STORE_MISALIGN,
        cause_timer          = `CTL_CAUSE_TIMER,
        cause_ecall_m        = `CTL_CAUSE_ECALL_M
    } trap_cause_e;

    // source of the next fetch address
    typedef enum logic [`CTL_SRC_BITS-1:0] {
        src_none,
        src_start,
        src_jal,
        src_branch,
        src_jalr,
        src_mret,
        src_trap
    } redirect_src_e;

endpackage

// File: rtl/ctl_sequencer.sv
`include "ctl_consts.svh"

module ctl_sequencer (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       start,
    input  logic                       jal_active,
    input  logic                       jalr_active,
    input  logic                       branch_active,
    input  logic [`CTL_PC_WIDTH-1:0]   jal_addr,
    input  logic [`CTL_PC_WIDTH-1:0]   jalr_addr,
    input  logic [`CTL_PC_WIDTH-1:0]   branch_addr,
    input  logic                       mret_active,
    input  logic                       decode_load,
    input  logic                       decode_store,
    input  logic                       load_done,
    input  logic                       store_done,
    input  logic                       exc_alignment,
    input  logic                       timer_triggered,
    input  logic                       cause_pending,
    input  logic                       interrupt_active,
    input  logic                       fetch_init,
    output ctl_pkg::redirect_src_e     redirect_src,
    output logic                       fetch_next,
    output logic                       exe_enable,
    output logic                       data_access_enable,
    output logic                       set_misalign,
    output logic                       set_interrupt,
    output logic                       clear_causes,
    output logic                       activate,
    output logic                       paused,
    output logic                       load_active,
    output logic                       store_active
);
    import ctl_pkg::*;

    ctl_state_e state;
    ctl_state_e state_next;
    logic       first_exe;
    logic       disable_data;
    logic       disable_data_set;
    logic       misalign_target;
    logic       jump_taken;

    // jump target not on a 4-byte boundary
    assign misalign_target = (jal_active & jal_addr[1]) |
                             (jalr_active & jalr_addr[1]) |
                             (branch_active & branch_addr[1]);

    assign jump_taken = jal_active | jalr_active | branch_active | mret_active;

    // ==================================================
    // registers
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_init;
        end else begin
            state <= state_next;
        end
    end

    // no data access until the first instruction after a redirect has executed
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            first_exe <= 1'b0;
        end else if (fetch_init) begin
            first_exe <= 1'b0;
        end else if (exe_enable) begin
            first_exe <= 1'b1;
        end
    end

    // a finished load/store suppresses data access for one fetch_exe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            disable_data <= 1'b0;
        end else begin
            disable_data <= disable_data_set;
        end
    end

    // ==================================================
    // next state and strobes
    // ==================================================
    always_comb begin
        state_next         = st_init;
        redirect_src       = src_none;
        fetch_next         = 1'b0;
        exe_enable         = 1'b0;
        data_access_enable = 1'b0;
        set_misalign       = 1'b0;
        set_interrupt      = 1'b0;
        clear_causes       = 1'b0;
        activate           = 1'b0;
        paused             = 1'b0;
        load_active        = 1'b0;
        store_active       = 1'b0;
        disable_data_set   = 1'b0;

        case (state)
            st_init: begin
                paused = 1'b1;
                if (start) begin
                    redirect_src = src_start;
                    state_next   = st_init_wait;
                end else begin
                    state_next = st_init;
                end
            end

            st_init_wait: state_next = st_fetch;

            st_fetch: state_next = st_decode;

            st_decode: begin
                fetch_next = 1'b1;
                state_next = st_fetch_exe;
            end

            st_fetch_exe: begin
                data_access_enable = first_exe & ~disable_data;
                if (timer_triggered & ~interrupt_active) begin
                    set_interrupt = 1'b1;
                    state_next    = st_exception;
                end else if (misalign_target) begin
                    set_misalign = 1'b1;
                    state_next   = st_exception;
                end else if (cause_pending & data_access_enable) begin
                    state_next = st_exception;
                end else if (jump_taken) begin
                    // same precedence as the execution unit reports them
                    if (jal_active) begin
                        redirect_src = src_jal;
                    end else if (branch_active) begin
                        redirect_src = src_branch;
                    end else if (jalr_active) begin
                        redirect_src = src_jalr;
                    end else begin
                        redirect_src = src_mret;
                    end
                    state_next = st_init_wait;
                end else begin
                    state_next = st_decode_data;
                end
            end

            st_decode_data: begin
                exe_enable = 1'b1;
                if (decode_store) begin
                    state_next = st_store;
                end else if (decode_load) begin
                    state_next = st_load;
                end else begin
                    fetch_next = 1'b1;
                    state_next = st_fetch_exe;
                end
            end

            st_store: begin
                data_access_enable = 1'b1;
                store_active       = 1'b1;
                state_next         = st_store_wait;
            end

            st_store_wait: begin
                if (exc_alignment) begin
                    state_next = st_exception;
                end else if (store_done) begin
                    fetch_next       = 1'b1;
                    disable_data_set = 1'b1;
                    state_next       = st_fetch_exe;
                end else begin
                    state_next = st_store_wait;
                end
            end

            st_load: begin
                data_access_enable = 1'b1;
                load_active        = 1'b1;
                state_next         = st_load_wait;
            end

            st_load_wait: begin
                if (exc_alignment) begin
                    state_next = st_exception;
                end else if (load_done) begin
                    fetch_next       = 1'b1;
                    disable_data_set = 1'b1;
                    state_next       = st_fetch_exe;
                end else begin
                    state_next = st_load_wait;
                end
            end

            // cause code settles here, CSR file sees it next cycle
            st_exception: begin
                activate   = 1'b1;
                state_next = st_exception_reinit;
            end

            st_exception_reinit: begin
                redirect_src = src_trap;
                clear_causes = 1'b1;
                state_next   = st_init_wait;
            end

            default: state_next = st_init;
        endcase
    end

endmodule

// File: rtl/trap_cause_unit.sv
`include "ctl_consts.svh"

module trap_cause_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   exc_ecall,
    input  logic                   exc_ebreak,
    input  logic                   exc_alignment,
    input  logic                   set_misalign,
    input  logic                   set_interrupt,
    input  logic                   clear_causes,
    input  logic                   timer_triggered,
    input  logic                   load_active,
    input  logic                   store_active,
    output logic                   cause_pending,
    output logic                   interrupt_active,
    output logic                   is_interrupt,
    output ctl_pkg::trap_cause_e   cause_code
);
    import ctl_pkg::*;

    logic ecall_q;
    logic ebreak_q;
    logic misalign_q;
    logic align_q;
    logic load_dir_q;
    logic set_interrupt_q;

    // live pulses count too, so the sequencer reacts in the same cycle
    assign cause_pending = ecall_q | ebreak_q | misalign_q | align_q |
                           exc_ecall | exc_ebreak | exc_alignment;

    // ==================================================
    // sticky cause flags
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ecall_q    <= 1'b0;
            ebreak_q   <= 1'b0;
            misalign_q <= 1'b0;
            align_q    <= 1'b0;
        end else if (clear_causes) begin
            ecall_q    <= 1'b0;
            ebreak_q   <= 1'b0;
            misalign_q <= 1'b0;
            align_q    <= 1'b0;
        end else begin
            ecall_q    <= ecall_q | exc_ecall;
            ebreak_q   <= ebreak_q | exc_ebreak;
            misalign_q <= misalign_q | set_misalign;
            align_q    <= align_q | exc_alignment;
        end
    end

    // direction of the last data access, picks load vs store misalign
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            load_dir_q <= 1'b0;
        end else if (load_active) begin
            load_dir_q <= 1'b1;
        end else if (store_active) begin
            load_dir_q <= 1'b0;
        end
    end

    // timer stays masked until the level drops
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            interrupt_active <= 1'b0;
            set_interrupt_q  <= 1'b0;
        end else begin
            set_interrupt_q <= set_interrupt;
            if (set_interrupt) begin
                interrupt_active <= 1'b1;
            end else if (!timer_triggered) begin
                interrupt_active <= 1'b0;
            end
        end
    end

    // ==================================================
    // cause priority
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cause_code   <= cause_instr_misalign;
            is_interrupt <= 1'b0;
        end else begin
            is_interrupt <= set_interrupt_q;
            if (set_interrupt_q) begin
                cause_code <= cause_timer;
            end else if (ecall_q) begin
                cause_code <= cause_ecall_m;
            end else if (ebreak_q) begin
                cause_code <= cause_breakpoint;
            end else if (misalign_q) begin
                cause_code <= cause_instr_misalign;
            end else if (align_q) begin
                cause_code <= load_dir_q ? cause_load_misalign : cause_store_misalign;
            end
        end
    end

endmodule

// File: rtl/fetch_redirect.sv
`include "ctl_consts.svh"

module fetch_redirect (
    input  logic                       clk,
    input  logic                       reset_n,
    input  ctl_pkg::redirect_src_e     redirect_src,
    input  logic [`CTL_PC_WIDTH-1:0]   start_addr,
    input  logic [`CTL_PC_WIDTH-1:0]   jal_addr,
    input  logic [`CTL_PC_WIDTH-1:0]   jalr_addr,
    input  logic [`CTL_PC_WIDTH-1:0]   branch_addr,
    input  logic [`CTL_PC_WIDTH-1:0]   pc,
    input  logic [`CTL_XLEN-1:0]       mtvec,
    input  logic [`CTL_XLEN-1:0]       mepc,
    input  ctl_pkg::trap_cause_e       cause_code,
    input  logic                       activate,
    input  logic                       data_access_enable,
    output logic                       fetch_init,
    output logic [`CTL_PC_WIDTH-1:0]   fetch_start_addr,
    output logic                       activate_exception,
    output logic [`CTL_PC_WIDTH-1:0]   exception_pc
);
    import ctl_pkg::*;

    logic [`CTL_XLEN-1:0] trap_vector;

    // direct mode when mode bits are zero, else base + 4 * cause
    assign trap_vector = (mtvec[1:0] == 2'b00) ? mtvec :
        {mtvec[`CTL_XLEN-1:2], 2'b00} +
        {{(`CTL_XLEN - `CTL_CAUSE_BITS - 2){1'b0}}, cause_code, 2'b00};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_init         <= 1'b0;
            fetch_start_addr   <= '0;
            activate_exception <= 1'b0;
        end else begin
            fetch_init         <= (redirect_src != src_none);
            activate_exception <= activate;
            case (redirect_src)
                src_start:  fetch_start_addr <= {start_addr[`CTL_PC_WIDTH-1:1], 1'b0};
                src_jal:    fetch_start_addr <= {jal_addr[`CTL_PC_WIDTH-1:1], 1'b0};
                src_branch: fetch_start_addr <= {branch_addr[`CTL_PC_WIDTH-1:1], 1'b0};
                src_jalr:   fetch_start_addr <= {jalr_addr[`CTL_PC_WIDTH-1:1], 1'b0};
                src_mret:   fetch_start_addr <= mepc;
                src_trap:   fetch_start_addr <= trap_vector;
                default:    fetch_start_addr <= fetch_start_addr;
            endcase
        end
    end

    // pc of the instruction that owns the data phase, becomes mepc on a trap
    always_ff @(posedge clk) begin
        if (data_access_enable) begin
            exception_pc <= pc;
        end
    end

endmodule

// File: rtl/core_controller.sv
`include "ctl_consts.svh"

module core_controller (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       start,
    input  logic [`CTL_PC_WIDTH-1:0]   start_addr,
    input  logic                       jal_active,
    input  logic [`CTL_PC_WIDTH-1:0]   jal_addr,
    input  logic                       jalr_active,
    input  logic [`CTL_PC_WIDTH-1:0]   jalr_addr,
    input  logic                       branch_active,
    input  logic [`CTL_PC_WIDTH-1:0]   branch_addr,
    input  logic                       mret_active,
    input  logic                       decode_load,
    input  logic                       decode_store,
    input  logic                       load_done,
    input  logic                       store_done,
    input  logic [`CTL_XLEN-1:0]       mtvec,
    input  logic [`CTL_XLEN-1:0]       mepc,
    input  logic [`CTL_PC_WIDTH-1:0]   pc,
    input  logic                       exc_ecall,
    input  logic                       exc_ebreak,
    input  logic                       exc_alignment,
    input  logic                       timer_triggered,
    output logic                       fetch_init,
    output logic [`CTL_PC_WIDTH-1:0]   fetch_start_addr,
    output logic                       fetch_next,
    output logic                       exe_enable,
    output logic                       data_access_enable,
    output logic                       activate_exception,
    output ctl_pkg::trap_cause_e       exception_code,
    output logic                       is_interrupt,
    output logic [`CTL_PC_WIDTH-1:0]   exception_pc,
    output logic                       paused
);
    import ctl_pkg::*;

    redirect_src_e redirect_src;
    logic          set_misalign;
    logic          set_interrupt;
    logic          clear_causes;
    logic          activate;
    logic          load_active;
    logic          store_active;
    logic          cause_pending;
    logic          interrupt_active;

    // ==================================================
    // state machine
    // ==================================================
    ctl_sequencer u_sequencer (
        .clk                (clk),
        .reset_n            (reset_n),
        .start              (start),
        .jal_active         (jal_active),
        .jalr_active        (jalr_active),
        .branch_active      (branch_active),
        .jal_addr           (jal_addr),
        .jalr_addr          (jalr_addr),
        .branch_addr        (branch_addr),
        .mret_active        (mret_active),
        .decode_load        (decode_load),
        .decode_store       (decode_store),
        .load_done          (load_done),
        .store_done         (store_done),
        .exc_alignment      (exc_alignment),
        .timer_triggered    (timer_triggered),
        .cause_pending      (cause_pending),
        .interrupt_active   (interrupt_active),
        .fetch_init         (fetch_init),
        .redirect_src       (redirect_src),
        .fetch_next         (fetch_next),
        .exe_enable         (exe_enable),
        .data_access_enable (data_access_enable),
        .set_misalign       (set_misalign),
        .set_interrupt      (set_interrupt),
        .clear_causes       (clear_causes),
        .activate           (activate),
        .paused             (paused),
        .load_active        (load_active),
        .store_active       (store_active)
    );

    // trap causes and mcause code
    trap_cause_unit u_trap_cause (
        .clk              (clk),
        .reset_n          (reset_n),
        .exc_ecall        (exc_ecall),
        .exc_ebreak       (exc_ebreak),
        .exc_alignment    (exc_alignment),
        .set_misalign     (set_misalign),
        .set_interrupt    (set_interrupt),
        .clear_causes     (clear_causes),
        .timer_triggered  (timer_triggered),
        .load_active      (load_active),
        .store_active     (store_active),
        .cause_pending    (cause_pending),
        .interrupt_active (interrupt_active),
        .is_interrupt     (is_interrupt),
        .cause_code       (exception_code)
    );

    // fetch address and CSR-side outputs
    fetch_redirect u_fetch_redirect (
        .clk                (clk),
        .reset_n            (reset_n),
        .redirect_src       (redirect_src),
        .start_addr         (start_addr),
        .jal_addr           (jal_addr),
        .jalr_addr          (jalr_addr),
        .branch_addr        (branch_addr),
        .pc                 (pc),
        .mtvec              (mtvec),
        .mepc               (mepc),
        .cause_code         (exception_code),
        .activate           (activate),
        .data_access_enable (data_access_enable),
        .fetch_init         (fetch_init),
        .fetch_start_addr   (fetch_start_addr),
        .activate_exception (activate_exception),
        .exception_pc       (exception_pc)
    );

endmodule

// File: test/ctl_ref_model.svh
`ifndef CTL_REF_MODEL_SVH
`define CTL_REF_MODEL_SVH

// next fetch address for a given redirect source
function automatic logic [`CTL_PC_WIDTH-1:0] expected_fetch_addr(
    input redirect_src_e              src,
    input logic [`CTL_PC_WIDTH-1:0]   target,
    input logic [`CTL_XLEN-1:0]       tvec,
    input logic [`CTL_XLEN-1:0]       epc,
    input logic [`CTL_CAUSE_BITS-1:0] cause
);
    logic [`CTL_XLEN-1:0] base;
    base = tvec & ~32'h3;
    case (src)
        src_mret: return epc;
        src_trap: begin
            // direct mode jumps to mtvec, vectored adds four per cause
            if (tvec[1:0] == 2'b00) begin
                return tvec;
            end
            return base + (32'(cause) << 2);
        end
        default: return target & ~32'h1;
    endcase
endfunction

// mcause code from the set of causes that were injected
function automatic logic [`CTL_CAUSE_BITS-1:0] resolve_cause_code(
    input logic timer,
    input logic ecall,
    input logic ebreak,
    input logic misalign,
    input logic align,
    input logic was_load
);
    if (timer) return `CTL_CAUSE_TIMER;
    if (ecall) return `CTL_CAUSE_ECALL_M;
    if (ebreak) return `CTL_CAUSE_BREAKPOINT;
    if (misalign) return `CTL_CAUSE_INSTR_MISALIGN;
    if (align && was_load) return `CTL_CAUSE_LOAD_MISALIGN;
    return `CTL_CAUSE_STORE_MISALIGN;
endfunction

`endif

// File: test/tb_core_controller.sv
`include "ctl_consts.svh"

module tb_core_controller;
    import ctl_pkg::*;

    `include "ctl_ref_model.svh"

    localparam int max_cycles = 4000;

    logic                       clk;
    logic                       reset_n;
    logic                       start;
    logic [`CTL_PC_WIDTH-1:0]   start_addr;
    logic                       jal_active;
    logic [`CTL_PC_WIDTH-1:0]   jal_addr;
    logic                       jalr_active;
    logic [`CTL_PC_WIDTH-1:0]   jalr_addr;
    logic                       branch_active;
    logic [`CTL_PC_WIDTH-1:0]   branch_addr;
    logic                       mret_active;
    logic                       decode_load;
    logic                       decode_store;
    logic                       load_done;
    logic                       store_done;
    logic [`CTL_XLEN-1:0]       mtvec;
    logic [`CTL_XLEN-1:0]       mepc;
    logic [`CTL_PC_WIDTH-1:0]   pc;
    logic                       exc_ecall;
    logic                       exc_ebreak;
    logic                       exc_alignment;
    logic                       timer_triggered;
    logic                       fetch_init;
    logic [`CTL_PC_WIDTH-1:0]   fetch_start_addr;
    logic                       fetch_next;
    logic                       exe_enable;
    logic                       data_access_enable;
    logic                       activate_exception;
    trap_cause_e                exception_code;
    logic                       is_interrupt;
    logic [`CTL_PC_WIDTH-1:0]   exception_pc;
    logic                       paused;

    int   errors;
    int   checks;
    int   cycles;
    int   test_base;
    logic fe_next;
    logic [`CTL_PC_WIDTH-1:0]   addr_q[$];
    logic [`CTL_CAUSE_BITS-1:0] code_q[$];
    logic                       intr_q[$];
    logic [`CTL_PC_WIDTH-1:0]   epc_q[$];

    core_controller dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================
    // helpers
    // ==================================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // the cycle after fetch_next is always fetch_exe
    task automatic wait_fetch_exe();
        do begin
            @(negedge clk);
        end while (!fe_next);
    endtask

    task automatic clear_jumps();
        jal_active    = 1'b0;
        jalr_active   = 1'b0;
        branch_active = 1'b0;
        mret_active   = 1'b0;
    endtask

    task automatic expect_trap(input logic [`CTL_CAUSE_BITS-1:0] code, input logic intr,
                               input logic [`CTL_PC_WIDTH-1:0] epc);
        code_q.push_back(code);
        intr_q.push_back(intr);
        epc_q.push_back(epc);
        addr_q.push_back(expected_fetch_addr(src_trap, '0, mtvec, mepc, code));
    endtask

    task automatic wait_trap();
        while (!activate_exception) @(negedge clk);
        while (!fetch_init) @(negedge clk);
    endtask

    // one load or store, either completed or aborted by an alignment fault
    task automatic data_access(input logic is_load, input int delay, input logic fault);
        logic [`CTL_PC_WIDTH-1:0] access_pc;
        wait_fetch_exe();
        @(negedge clk);
        check_value("exe_enable", 1, exe_enable);
        decode_load  = is_load;
        decode_store = !is_load;
        access_pc    = $urandom & ~32'h3;
        pc           = access_pc;
        @(negedge clk);
        decode_load  = 1'b0;
        decode_store = 1'b0;
        @(negedge clk);
        // fetch has moved on while the access waits
        pc = access_pc + 4;
        repeat (delay) begin
            check_value("exe_enable", 0, exe_enable);
            check_value("fetch_init", 0, fetch_init);
            @(negedge clk);
        end
        if (fault) begin
            exc_alignment = 1'b1;
            expect_trap(resolve_cause_code(0, 0, 0, 0, 1, is_load), 1'b0, access_pc);
            @(negedge clk);
            exc_alignment = 1'b0;
            wait_trap();
            pc = access_pc;
        end else begin
            load_done  = is_load;
            store_done = !is_load;
            @(negedge clk);
            load_done  = 1'b0;
            store_done = 1'b0;
            checks++;
            assert (fe_next) else begin
                $display("data access did not return to fetch_next after done");
                errors++;
            end
        end
    endtask

    // ==================================================
    // compare process
    // ==================================================
    always @(posedge clk) begin
        cycles  = cycles + 1;
        fe_next = fetch_next;
        if (fetch_init) begin
            checks++;
            assert (addr_q.size() > 0) begin
                check_value("fetch_start_addr", addr_q.pop_front(), fetch_start_addr);
            end else begin
                $display("fetch_init pulsed while no redirect was expected");
                errors++;
            end
        end
        if (activate_exception) begin
            checks++;
            assert (code_q.size() > 0) begin
                check_value("exception_code", code_q.pop_front(), exception_code);
                check_value("is_interrupt", intr_q.pop_front(), is_interrupt);
                check_value("exception_pc", epc_q.pop_front(), exception_pc);
            end else begin
                $display("activate_exception pulsed while no trap was expected");
                errors++;
            end
        end
    end

    initial begin
        wait (cycles >= max_cycles);
        $display("timeout after %0d cycles, the tests did not finish", max_cycles);
        $display("Simulation failed");
        $finish;
    end

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        int            kind;
        logic [31:0]   target;
        redirect_src_e src;

        void'($urandom(23));
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        test_base       = 0;
        fe_next         = 1'b0;
        reset_n         = 1'b0;
        start           = 1'b0;
        start_addr      = '0;
        jal_addr        = '0;
        jalr_addr       = '0;
        branch_addr     = '0;
        clear_jumps();
        decode_load     = 1'b0;
        decode_store    = 1'b0;
        load_done       = 1'b0;
        store_done      = 1'b0;
        mtvec           = '0;
        mepc            = '0;
        pc              = 32'h100;
        exc_ecall       = 1'b0;
        exc_ebreak      = 1'b0;
        exc_alignment   = 1'b0;
        timer_triggered = 1'b0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;

        // reset values, then start
        @(negedge clk);
        check_value("paused", 1, paused);
        check_value("fetch_init", 0, fetch_init);
        check_value("fetch_next", 0, fetch_next);
        check_value("exe_enable", 0, exe_enable);
        check_value("data_access_enable", 0, data_access_enable);
        check_value("activate_exception", 0, activate_exception);
        check_value("is_interrupt", 0, is_interrupt);
        check_value("fetch_start_addr", 0, fetch_start_addr);
        check_value("exception_code", 0, exception_code);
        start = 1'b1;
        start_addr = $urandom;
        addr_q.push_back(expected_fetch_addr(src_start, start_addr, mtvec, mepc, 0));
        @(negedge clk);
        start = 1'b0;
        check_value("fetch_init", 1, fetch_init);
        finish_test("reset_start");

        repeat (8) begin
            wait_fetch_exe();
            kind   = $urandom_range(0, 3);
            target = $urandom & ~32'h2;
            case (kind)
                0: begin
                    jal_active = 1'b1;
                    jal_addr   = target;
                    src        = src_jal;
                end
                1: begin
                    jalr_active = 1'b1;
                    jalr_addr   = target;
                    src         = src_jalr;
                end
                2: begin
                    branch_active = 1'b1;
                    branch_addr   = target;
                    src           = src_branch;
                end
                default: begin
                    mepc        = $urandom;
                    mret_active = 1'b1;
                    src         = src_mret;
                end
            endcase
            addr_q.push_back(expected_fetch_addr(src, target, mtvec, mepc, 0));
            @(negedge clk);
            clear_jumps();
        end
        finish_test("redirects");

        repeat (8) data_access($urandom_range(0, 1), $urandom_range(0, 5), 1'b0);
        finish_test("load_store_stall");

        // direct then vectored mtvec
        for (int mode = 0; mode < 2; mode++) begin
            for (int k = 0; k < 3; k++) begin
                mtvec = ($urandom & ~32'h3) | mode;
                wait_fetch_exe();
                case (k)
                    0: exc_ecall = 1'b1;
                    1: exc_ebreak = 1'b1;
                    default: begin
                        jal_active = 1'b1;
                        jal_addr   = $urandom | 32'h2;
                    end
                endcase
                expect_trap(resolve_cause_code(0, k == 0, k == 1, k == 2, 0, 0), 1'b0, pc);
                @(negedge clk);
                exc_ecall = 1'b0;
                exc_ebreak = 1'b0;
                clear_jumps();
                wait_trap();
            end
        end
        finish_test("sync_traps");

        data_access(1'b1, $urandom_range(0, 5), 1'b1);
        data_access(1'b0, $urandom_range(0, 5), 1'b1);
        wait_fetch_exe();
        timer_triggered = 1'b1;
        expect_trap(resolve_cause_code(1, 0, 0, 0, 0, 0), 1'b1, pc);
        wait_trap();
        // level still high, no further trap allowed
        repeat (3) wait_fetch_exe();
        timer_triggered = 1'b0;
        wait_fetch_exe();
        timer_triggered = 1'b1;
        expect_trap(resolve_cause_code(1, 0, 0, 0, 0, 0), 1'b1, pc);
        wait_trap();
        timer_triggered = 1'b0;
        finish_test("alignment_timer");

        while (addr_q.size() != 0 || code_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
+incdir+test
rtl/ctl_pkg.sv
rtl/ctl_sequencer.sv
rtl/trap_cause_unit.sv
rtl/fetch_redirect.sv
rtl/core_controller.sv
test/tb_core_controller.sv

// File: Bender.yml
package:
  name: core_controller

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ctl_pkg.sv
      - rtl/ctl_sequencer.sv
      - rtl/trap_cause_unit.sv
      - rtl/fetch_redirect.sv
      - rtl/core_controller.sv
  - target: test
    include_dirs:
      - rtl
      - test
    files:
      - test/tb_core_controller.sv
